/* dv/decode_input.txt */
# kind op mr off imm blk dstep intr ifl repz need len, then one ir word per step (hex)
# blk = most stall cycles per step, dstep = step with div_exc (f = none)
ins 90 00 0000 0000 0 f 0 0 0 00 1 7FFFF000000000
ins 89 c3 1111 2222 0 f 0 0 0 10 1 003FF000000000
ins 89 4a 0012 0000 0 f 0 0 0 18 1 01F56900120000
ins 81 c5 0000 1234 0 f 0 0 0 15 1 155FF000001234
ins 81 87 0340 00ff 0 f 0 0 0 1f 2 0F83FE03400000 18F3FD034000FF
ins bb 00 0000 beef 0 f 0 0 0 05 1 0F3FF00000BEEF
ins eb 00 0000 fff0 0 f 0 0 0 04 1 4FFFF00000FFF0
ins f7 f1 0000 0000 0 f 0 0 0 10 2 018FF000000000 38FFF000000000
ins 0f 00 0000 0000 0 f 0 0 0 00 1 6F836E00000000
ins f7 56 0007 0000 0 f 0 0 0 18 1 6F85FA00000000
blk 81 87 0340 00ff 3 f 0 0 0 1f 2 0F83FE03400000 18F3FD034000FF
blk f7 f1 0000 0000 2 f 0 0 0 10 2 018FF000000000 38FFF000000000
blk 89 4a 0012 0000 4 f 0 0 0 18 1 01F56900120000
ins f7 f1 0000 0000 0 0 0 0 0 10 2 018FF000000000 38FFF000000000
dsv f7 f1 0000 0000 0 f 0 0 0 10 3 5FF37D00000000 5FF37D00000000 6F837E00000000
ins f7 f1 0000 0000 0 f 0 0 0 10 2 018FF000000000 38FFF000000000
ins f7 74 0020 0000 0 1 0 0 0 18 2 048FF000000000 38FFF000000000
dsv f7 74 0020 0000 0 f 0 0 0 18 3 5FF6FD00000000 5FF6FD00000000 6F86FE00000000
ins 90 00 0000 0000 0 f 1 1 0 00 1 7FFFF000000000
isv 90 00 0000 0000 0 f 0 0 0 00 3 5FF36D00000000 5FF36D00000000 6F836E00000000
ins bb 00 0000 beef 0 f 1 1 1 05 1 0F3FF00000BEEF
isv bb 00 0000 beef 0 f 0 0 1 05 4 288FF000000000 5FF36D00000000 58F36D00000000 6F836E00000000
ins 81 c5 0000 1234 0 f 1 0 0 15 1 155FF000001234
ins 90 00 0000 0000 0 f 0 0 0 00 1 7FFFF000000000
ins 90 00 0000 0000 0 f 1 1 0 00 1 7FFFF000000000
rst 81 87 0340 00ff 0 f 0 0 0 1f 2 0F83FE03400000 18F3FD034000FF
ins 90 00 0000 0000 0 f 0 0 0 00 1 7FFFF000000000

/* list.f */
rtl/ucode_pkg.sv
rtl/opcode_deco.sv
rtl/seq_rom.sv
rtl/micro_data.sv
rtl/seq_ctrl.sv
rtl/decode_core.sv
dv/tb_decode.sv

/* run.sh */
#!/bin/sh
# compile and run the decoder testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_decode -f list.f -o tb_decode_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* dv/tb_decode.sv */
module tb_decode;
  import ucode_pkg::*;

  localparam int MAX_LINES  = 64;
  localparam int MAX_STEPS  = 4;
  localparam int CLK_PERIOD = 8;

  // record kinds
  localparam int K_INS = 0;
  localparam int K_BLK = 1;
  localparam int K_DSV = 2;
  localparam int K_ISV = 3;
  localparam int K_RST = 4;

  logic  clk;
  logic  rst;
  inst_t inst;
  logic  block;
  logic  exec_st;
  logic  div_exc;
  logic  intr;
  logic  ifl;
  logic  repz_pr;
  need_t need;
  ir_t   ir;
  logic  end_seq;
  logic  ext_int;
  logic  inta;

  // vector table, one entry per record
  int         kind_a  [MAX_LINES];
  inst_t      inst_a  [MAX_LINES];
  int         blk_a   [MAX_LINES];
  int         dstep_a [MAX_LINES];
  // intr, ifl, repz_pr
  logic [2:0] flag_a  [MAX_LINES];
  need_t      need_a  [MAX_LINES];
  int         len_a   [MAX_LINES];
  ir_t        word_a  [MAX_LINES][MAX_STEPS];
  int         n_lines;

  int   errors;
  int   checks;
  int   seed;
  int   rec;
  int   wd_cycles;
  logic wd_armed;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  decode_core dut0 (
    .clk     (clk),
    .rst     (rst),
    .inst    (inst),
    .block   (block),
    .exec_st (exec_st),
    .div_exc (div_exc),
    .intr    (intr),
    .ifl     (ifl),
    .repz_pr (repz_pr),
    .need    (need),
    .ir      (ir),
    .end_seq (end_seq),
    .ext_int (ext_int),
    .inta    (inta)
  );

  task automatic check_need(input need_t got, input need_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR need got 0x%h exp 0x%h (record %0d)", got, exp, rec);
    end
  endtask

  task automatic check_ir(input ir_t got, input ir_t exp, input int step);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR ir got 0x%h exp 0x%h (record %0d step %0d)", got, exp, rec, step);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp, input int step);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%h exp 0x%h (record %0d step %0d)", name, got, exp, rec, step);
    end
  endtask

  // token to record kind, -1 when unknown
  function automatic int kind_code(input logic [23:0] tok);
    case (tok)
      "ins":   return K_INS;
      "blk":   return K_BLK;
      "dsv":   return K_DSV;
      "isv":   return K_ISV;
      "rst":   return K_RST;
      default: return -1;
    endcase
  endfunction

  task automatic load_vectors();
    int          fd;
    int          c;
    int          rc;
    int          k;
    logic [23:0] tok;
    logic [7:0]  op;
    logic [7:0]  modrm;
    logic [15:0] off;
    logic [15:0] imm;
    int          blk_v;
    int          dstep_v;
    int          intr_v;
    int          ifl_v;
    int          repz_v;
    logic [4:0]  need_v;
    int          len_v;
    logic [55:0] w;
    n_lines = 0;
    fd = $fopen("dv/decode_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open dv/decode_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", tok);
      if (rc != 1) break;
      // comment line, skip to end of line
      if (tok == {16'h0000, "#"}) begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
        continue;
      end
      rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", op, modrm, off, imm,
                   blk_v, dstep_v, intr_v, ifl_v, repz_v, need_v, len_v);
      if (rc != 11 || kind_code(tok) < 0 || len_v < 1 || len_v > MAX_STEPS ||
          n_lines == MAX_LINES) begin
        errors++;
        $display("malformed vector record after %0d good records", n_lines);
        break;
      end
      kind_a[n_lines]  = kind_code(tok);
      inst_a[n_lines]  = {op, modrm, off, imm};
      blk_a[n_lines]   = blk_v;
      dstep_a[n_lines] = dstep_v;
      flag_a[n_lines]  = {intr_v[0], ifl_v[0], repz_v[0]};
      need_a[n_lines]  = need_v;
      len_a[n_lines]   = len_v;
      for (k = 0; k < len_v; k++) begin
        rc = $fscanf(fd, "%h", w);
        word_a[n_lines][k] = w[54:0];
      end
      n_lines++;
    end
    $fclose(fd);
  endtask

  // rst held for 4 rising edges, core left idle on release
  task automatic hold_reset();
    rst     = 1'b1;
    exec_st = 1'b0;
    block   = 1'b0;
    div_exc = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  // one cycle, outputs settle mid low phase
  task automatic drive_cycle(input int i, input logic blk, input logic dexc);
    @(negedge clk);
    inst    = inst_a[i];
    exec_st = 1'b1;
    block   = blk;
    div_exc = dexc;
    intr    = flag_a[i][2];
    ifl     = flag_a[i][1];
    repz_pr = flag_a[i][0];
    #2;
  endtask

  task automatic check_step(input int i, input int k);
    logic svc;
    logic last;
    svc  = (kind_a[i] == K_ISV);
    last = (k == len_a[i] - 1);
    check_ir(ir, word_a[i][k], k);
    if (last && end_seq !== 1'b1) begin
      errors++;
      $display("record %0d never raised end_seq within its %0d steps", rec, len_a[i]);
    end else begin
      check_bit("end_seq", end_seq, last, k);
    end
    // interrupt service shows ext_int throughout, inta on its second step
    check_bit("ext_int", ext_int, svc, k);
    check_bit("inta", inta, svc && (k == 1), k);
  endtask

  task automatic run_line(input int i);
    int steps;
    int stalls;
    int k;
    int s;
    rec   = i + 1;
    steps = len_a[i];
    // divide exception cuts the routine short
    if (dstep_a[i] < len_a[i]) steps = dstep_a[i] + 1;
    if (kind_a[i] == K_RST) begin
      // one step in flight, then reset
      drive_cycle(i, 1'b0, 1'b0);
      @(negedge clk);
      hold_reset();
    end
    for (k = 0; k < steps; k++) begin
      stalls = 0;
      if (blk_a[i] > 0) stalls = $unsigned($random(seed)) % (blk_a[i] + 1);
      for (s = 0; s < stalls; s++) begin
        drive_cycle(i, 1'b1, 1'b0);
        check_step(i, k);
      end
      drive_cycle(i, 1'b0, k == dstep_a[i]);
      if (k == 0) check_need(need, need_a[i]);
      check_step(i, k);
    end
  endtask

  // ends a run that stops making progress
  initial begin
    wait (wd_armed);
    #(wd_cycles * 2 * CLK_PERIOD + 400);
    $display("watchdog expired, the run did not finish within %0d cycles", wd_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int i;
    errors    = 0;
    checks    = 0;
    rec       = 0;
    seed      = 32'hed3ca1c3;
    wd_cycles = 8;
    wd_armed  = 1'b0;
    rst       = 1'b1;
    inst      = '0;
    block     = 1'b0;
    exec_st   = 1'b0;
    div_exc   = 1'b0;
    intr      = 1'b0;
    ifl       = 1'b0;
    repz_pr   = 1'b0;
    load_vectors();
    if (n_lines == 0) begin
      errors++;
      $display("no vector records were read");
    end
    // worst case stalls on every step, plus reset cycles
    for (i = 0; i < n_lines; i++) begin
      wd_cycles += len_a[i] * (blk_a[i] + 1) + 2;
      if (kind_a[i] == K_RST) wd_cycles += 7;
    end
    wd_armed = 1'b1;
    hold_reset();
    for (i = 0; i < n_lines; i++) begin
      run_line(i);
    end
    @(negedge clk);
    exec_st = 1'b0;
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/decode_core.sv */
module decode_core (
  input  logic             clk,
  input  logic             rst,
  input  ucode_pkg::inst_t inst,
  input  logic             block,
  input  logic             exec_st,
  input  logic             div_exc,
  input  logic             intr,
  input  logic             ifl,
  input  logic             repz_pr,
  output ucode_pkg::need_t need,
  output ucode_pkg::ir_t   ir,
  output logic             end_seq,
  output logic             ext_int,
  output logic             inta
);
  import ucode_pkg::*;

  seq_addr_t base_addr;
  seq_addr_t seq_addr;
  field_t    fields;
  micro_op_t uop;

  // last step flag straight from the rom word
  assign end_seq = uop.end_seq;

  opcode_deco u_opcode_deco (
    .opcode    (inst.opcode),
    .modrm     (inst.modrm),
    .base_addr (base_addr),
    .need      (need),
    .fields    (fields)
  );

  seq_ctrl u_seq_ctrl (
    .clk       (clk),
    .rst       (rst),
    .block     (block),
    .exec_st   (exec_st),
    .div_exc   (div_exc),
    .intr      (intr),
    .ifl       (ifl),
    .repz_pr   (repz_pr),
    .end_seq   (end_seq),
    .base_addr (base_addr),
    .seq_addr  (seq_addr),
    .ext_int   (ext_int),
    .inta      (inta)
  );

  seq_rom u_seq_rom (
    .addr (seq_addr),
    .uop  (uop)
  );

  micro_data u_micro_data (
    .uop    (uop),
    .fields (fields),
    .off    (inst.off),
    .imm    (inst.imm),
    .ir     (ir)
  );

endmodule

/* rtl/seq_ctrl.sv */
module seq_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 block,
  input  logic                 exec_st,
  input  logic                 div_exc,
  input  logic                 intr,
  input  logic                 ifl,
  input  logic                 repz_pr,
  input  logic                 end_seq,
  input  ucode_pkg::seq_addr_t base_addr,
  output ucode_pkg::seq_addr_t seq_addr,
  output logic                 ext_int,
  output logic                 inta
);
  import ucode_pkg::*;

  seq_addr_t step;
  seq_addr_t routine;
  logic      dive;
  logic      ext_int_q;
  logic      int_take;

  // divide beats interrupt beats opcode
  always_comb begin
    if (dive) begin
      routine = INTD_B;
    end else if (ext_int) begin
      routine = repz_pr ? EINTP_B : EINT_B;
    end else begin
      routine = base_addr;
    end
  end

  assign seq_addr = routine + step;

  // interrupt taken at an instruction boundary
  assign int_take = intr & ifl & exec_st & end_seq;

  // step counter
  always_ff @(posedge clk) begin
    if (rst) begin
      step <= '0;
    end else if (!block) begin
      if (div_exc || !exec_st || end_seq) begin
        step <= '0;
      end else begin
        step <= step + 5'd1;
      end
    end
  end

  // divide flag, held until intd finishes
  always_ff @(posedge clk) begin
    if (rst) begin
      dive <= 1'b0;
    end else if (!block) begin
      if (div_exc) begin
        dive <= 1'b1;
      end else if (dive && end_seq) begin
        dive <= 1'b0;
      end
    end
  end

  // external interrupt in service
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_int <= 1'b0;
    end else if (!block) begin
      if (int_take) begin
        ext_int <= 1'b1;
      end else if (ext_int && end_seq) begin
        ext_int <= 1'b0;
      end
    end
  end

  // rising edge of ext_int gives one acknowledge cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ext_int_q <= 1'b0;
      inta      <= 1'b0;
    end else if (!block) begin
      ext_int_q <= ext_int;
      inta      <= ext_int & ~ext_int_q;
    end
  end

endmodule

/* rtl/micro_data.sv */
module micro_data (
  input  ucode_pkg::micro_op_t uop,
  input  ucode_pkg::field_t    fields,
  input  logic [15:0]          off,
  input  logic [15:0]          imm,
  output ucode_pkg::ir_t       ir
);
  import ucode_pkg::*;

  logic mem_step;

  // selector to register number
  function automatic reg_t pick(input sel_e sel, input field_t f);
    reg_t r;
    case (sel)
      SEL_REG: r = f.src;
      SEL_RM:  r = f.dst;
      SEL_TMP: r = TMP_R;
      default: r = ZERO_R;
    endcase
    return r;
  endfunction

  // address fields only matter on a bus step
  assign mem_step = uop.mem_rd | uop.mem_wr;

  always_comb begin
    ir.alu_op = uop.alu_op;
    ir.src    = pick(uop.src_sel, fields);
    ir.dst    = pick(uop.dst_sel, fields);
    ir.mem_rd = uop.mem_rd;
    ir.mem_wr = uop.mem_wr;
    // effective address parts
    ir.base   = mem_step ? fields.base : ZERO_R;
    ir.index  = mem_step ? fields.index : ZERO_R;
    ir.seg    = mem_step ? fields.seg : 2'd0;
    // displacement and immediate
    ir.off    = uop.use_off ? off : 16'h0000;
    ir.imm    = uop.use_imm ? imm : 16'h0000;
  end

endmodule

/* rtl/seq_rom.sv */
module seq_rom (
  input  ucode_pkg::seq_addr_t  addr,
  output ucode_pkg::micro_op_t  uop
);
  import ucode_pkg::*;

  rom_word_t word;

  // pack one micro-op
  function automatic micro_op_t mk(
    input alu_op_e op,
    input sel_e    src,
    input sel_e    dst,
    input logic    off,
    input logic    imm,
    input logic    rd,
    input logic    wr,
    input logic    last
  );
    micro_op_t m;
    m.alu_op  = op;
    m.src_sel = src;
    m.dst_sel = dst;
    m.use_off = off;
    m.use_imm = imm;
    m.mem_rd  = rd;
    m.mem_wr  = wr;
    m.end_seq = last;
    return m;
  endfunction

  always_comb begin
    case (addr)
      // nop
      5'd0:  word.uop = mk(ALU_NOP,  SEL_NONE, SEL_NONE, 0, 0, 0, 0, 1);
      // mov r/m,r register then memory form
      5'd1:  word.uop = mk(ALU_PASS, SEL_REG,  SEL_RM,   0, 0, 0, 0, 1);
      5'd2:  word.uop = mk(ALU_PASS, SEL_REG,  SEL_NONE, 1, 0, 0, 1, 1);
      // add r/m,imm16
      5'd3:  word.uop = mk(ALU_ADD,  SEL_RM,   SEL_RM,   0, 1, 0, 0, 1);
      // memory form reads into temp first
      5'd4:  word.uop = mk(ALU_PASS, SEL_NONE, SEL_TMP,  1, 0, 1, 0, 0);
      5'd5:  word.uop = mk(ALU_ADD,  SEL_TMP,  SEL_NONE, 1, 1, 0, 1, 1);
      // mov r,imm16
      5'd6:  word.uop = mk(ALU_PASS, SEL_NONE, SEL_RM,   0, 1, 0, 0, 1);
      // jmp rel8
      5'd7:  word.uop = mk(ALU_JMP,  SEL_NONE, SEL_NONE, 0, 1, 0, 0, 1);
      // div, operand staged in temp
      5'd8:  word.uop = mk(ALU_PASS, SEL_RM,   SEL_TMP,  0, 0, 0, 0, 0);
      5'd9:  word.uop = mk(ALU_DIV,  SEL_TMP,  SEL_NONE, 0, 0, 0, 0, 1);
      // invalid opcode trap
      5'd10: word.uop = mk(ALU_LOAD_VEC, SEL_NONE, SEL_TMP, 0, 0, 1, 0, 1);
      // divide error service
      5'd11: word.uop = mk(ALU_PUSH, SEL_NONE, SEL_NONE, 0, 0, 0, 1, 0);
      5'd12: word.uop = mk(ALU_PUSH, SEL_NONE, SEL_NONE, 0, 0, 0, 1, 0);
      5'd13: word.uop = mk(ALU_LOAD_VEC, SEL_NONE, SEL_TMP, 0, 0, 1, 0, 1);
      // external interrupt
      5'd14: word.uop = mk(ALU_PUSH, SEL_NONE, SEL_NONE, 0, 0, 0, 1, 0);
      5'd15: word.uop = mk(ALU_PUSH, SEL_NONE, SEL_NONE, 0, 0, 0, 1, 0);
      5'd16: word.uop = mk(ALU_LOAD_VEC, SEL_NONE, SEL_TMP, 0, 0, 1, 0, 1);
      // rep pending, return ip backed up first
      5'd17: word.uop = mk(ALU_SUB,  SEL_TMP,  SEL_TMP,  0, 0, 0, 0, 0);
      5'd18: word.uop = mk(ALU_PUSH, SEL_NONE, SEL_NONE, 0, 0, 0, 1, 0);
      5'd19: word.uop = mk(ALU_PUSH, SEL_TMP,  SEL_NONE, 0, 0, 0, 1, 0);
      5'd20: word.uop = mk(ALU_LOAD_VEC, SEL_NONE, SEL_TMP, 0, 0, 1, 0, 1);
      // stray address ends at once
      default: word.uop = mk(ALU_NOP, SEL_NONE, SEL_NONE, 0, 0, 0, 0, 1);
    endcase
  end

  assign uop = word.uop;

endmodule

/* rtl/opcode_deco.sv */
module opcode_deco (
  input  logic [7:0]          opcode,
  input  logic [7:0]          modrm,
  output ucode_pkg::seq_addr_t base_addr,
  output ucode_pkg::need_t     need,
  output ucode_pkg::field_t    fields
);
  import ucode_pkg::*;

  logic [1:0] mod_f;
  logic [2:0] reg_f;
  logic [2:0] rm_f;
  logic       mem_form;
  logic       off_need;
  logic       off_wide;
  logic       is_movri;

  // modrm split
  assign mod_f = modrm[7:6];
  assign reg_f = modrm[5:3];
  assign rm_f  = modrm[2:0];

  // mod 3 is register direct
  assign mem_form = (mod_f != 2'b11);
  // disp8 on mod 1, disp16 on mod 2
  assign off_need = (mod_f == 2'b01) || (mod_f == 2'b10);
  assign off_wide = (mod_f == 2'b10);
  // b8..bf carry the register in the opcode
  assign is_movri = (opcode[7:3] == 5'b10111);

  // routine select and field needs
  always_comb begin
    base_addr = INV_B;
    need      = '0;
    casez (opcode)
      8'h90: begin
        base_addr = NOP_B;
      end
      8'h89: begin
        base_addr       = MOVRM_B + seq_addr_t'(mem_form);
        need.need_modrm = 1'b1;
        need.need_off   = off_need;
        need.off_size   = off_wide;
      end
      8'h81: begin
        base_addr       = ADDI_B + seq_addr_t'(mem_form);
        need.need_modrm = 1'b1;
        need.need_off   = off_need;
        need.off_size   = off_wide;
        need.need_imm   = 1'b1;
        need.imm_size   = 1'b1;
      end
      8'b1011_1???: begin
        base_addr     = MOVRI_B;
        need.need_imm = 1'b1;
        need.imm_size = 1'b1;
      end
      8'heb: begin
        // rel8, widened by fetch
        base_addr     = JMP8_B;
        need.need_imm = 1'b1;
      end
      8'hf7: begin
        // group 3, only reg 6 is div
        base_addr       = (reg_f == 3'd6) ? DIV_B : INV_B;
        need.need_modrm = 1'b1;
        need.need_off   = off_need;
        need.off_size   = off_wide;
      end
      default: base_addr = INV_B;
    endcase
  end

  // register fields
  assign fields.src = is_movri ? {1'b0, opcode[2:0]} : {1'b0, reg_f};
  assign fields.dst = is_movri ? {1'b0, opcode[2:0]} : {1'b0, rm_f};

  // 16-bit effective address table
  always_comb begin
    fields.index = ZERO_R;
    fields.seg   = SEG_DS;
    case (rm_f)
      3'd0: begin fields.base = 4'd3; fields.index = 4'd6; end
      3'd1: begin fields.base = 4'd3; fields.index = 4'd7; end
      3'd2: begin fields.base = 4'd5; fields.index = 4'd6; fields.seg = SEG_SS; end
      3'd3: begin fields.base = 4'd5; fields.index = 4'd7; fields.seg = SEG_SS; end
      3'd4: fields.base = 4'd6;
      3'd5: fields.base = 4'd7;
      3'd6: begin fields.base = 4'd5; fields.seg = SEG_SS; end
      default: fields.base = 4'd3;
    endcase
  end

endmodule

/* rtl/ucode_pkg.sv */
package ucode_pkg;

  // micro-rom address, 32 words
  typedef logic [4:0] seq_addr_t;

  // routine entry points
  // memory form of a routine sits one word past its register form
  localparam seq_addr_t NOP_B   = 5'd0;   // 1 step
  localparam seq_addr_t MOVRM_B = 5'd1;   // reg form 1 step, mem form 1 step at 2
  localparam seq_addr_t ADDI_B  = 5'd3;   // reg form 1 step, mem form 2 steps at 4
  localparam seq_addr_t MOVRI_B = 5'd6;   // 1 step
  localparam seq_addr_t JMP8_B  = 5'd7;   // 1 step
  localparam seq_addr_t DIV_B   = 5'd8;   // 2 steps
  localparam seq_addr_t INV_B   = 5'd10;  // 1 step
  localparam seq_addr_t INTD_B  = 5'd11;  // 3 steps
  localparam seq_addr_t EINT_B  = 5'd14;  // 3 steps
  localparam seq_addr_t EINTP_B = 5'd17;  // 4 steps

  // 0..7 general, 8..15 segment and temp
  typedef logic [3:0] reg_t;

  localparam reg_t TMP_R  = 4'd8;
  // reads as zero, marks an unused register slot
  localparam reg_t ZERO_R = 4'd15;

  // x86 sreg encoding
  localparam logic [1:0] SEG_SS = 2'd2;
  localparam logic [1:0] SEG_DS = 2'd3;

  typedef enum logic [2:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_SUB,
    ALU_DIV,
    ALU_JMP,
    ALU_PUSH,
    ALU_LOAD_VEC,
    ALU_NOP
  } alu_op_e;

  // register operand source
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_REG,
    SEL_RM,
    SEL_TMP
  } sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    sel_e    src_sel;
    sel_e    dst_sel;
    logic    use_off;
    logic    use_imm;
    logic    mem_rd;
    logic    mem_wr;
    logic    end_seq;
  } micro_op_t;

  typedef struct packed {
    micro_op_t uop;
  } rom_word_t;

  // fetch side view of one instruction
  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  modrm;
    logic [15:0] off;
    logic [15:0] imm;
  } inst_t;

  // size bits are 1 for 16-bit fields
  typedef struct packed {
    logic need_modrm;
    logic need_off;
    logic need_imm;
    logic off_size;
    logic imm_size;
  } need_t;

  typedef struct packed {
    reg_t       src;
    reg_t       dst;
    reg_t       base;
    reg_t       index;
    logic [1:0] seg;
  } field_t;

  typedef struct packed {
    alu_op_e     alu_op;
    reg_t        src;
    reg_t        dst;
    reg_t        base;
    reg_t        index;
    logic [1:0]  seg;
    logic        mem_rd;
    logic        mem_wr;
    logic [15:0] off;
    logic [15:0] imm;
  } ir_t;

endpackage
